// File: source/hsdPkg.sv
package hsdPkg;

    //////////////////////////////////////////////////////////////////////
    // Register file geometry
    localparam int gpioWordWidth = 32;
    localparam int gpioIdxWidth  = 3;
    localparam int gpioIdxCount  = 5;

    // Register indices
    localparam logic [gpioIdxWidth-1:0] gpioIdxBuildDate    = 3'd0;
    localparam logic [gpioIdxWidth-1:0] gpioIdxMicroseconds = 3'd1;
    localparam logic [gpioIdxWidth-1:0] gpioIdxSoftTrigger  = 3'd2;
    localparam logic [gpioIdxWidth-1:0] gpioIdxInterlockCsr = 3'd3;
    localparam logic [gpioIdxWidth-1:0] gpioIdxUserGpioCsr  = 3'd4;

    // Firmware identification
    localparam logic [gpioWordWidth-1:0] firmwareBuildDate = 32'h2024_0611;

    //////////////////////////////////////////////////////////////////////
    // Timing and widths

    // 100 ns sysClk period
    localparam int clksPerMicrosecond = 10;

    localparam int evrTriggerWidth    = 8;
    localparam int acqTriggerWidth    = 7;
    localparam int softTriggerStretch = 8;
    localparam int ledCount           = 8;
    localparam int dipWidth           = 8;

    //////////////////////////////////////////////////////////////////////
    // Bundles

    // One host request, held stable while hostReq is high
    typedef struct packed {
        logic                     write;
        logic [gpioIdxWidth-1:0]  index;
        logic [gpioWordWidth-1:0] data;
    } hostBusT;

    // Write strobes and their data word
    typedef struct packed {
        logic                     softTrigger;
        logic                     interlockWrite;
        logic [gpioWordWidth-1:0] writeData;
    } regStrobesT;

    // Words read back through the register bank
    typedef struct packed {
        logic [gpioWordWidth-1:0] microseconds;
        logic [gpioWordWidth-1:0] interlockCsr;
        logic [gpioWordWidth-1:0] userGpioCsr;
    } statusWordsT;

endpackage

// File: source/gpioRegisterBank.sv
`timescale 1ns/1ps

module gpioRegisterBank (
    input  logic                             sysClk,
    input  logic                             reset,
    input  logic                             hostReq,
    input  hsdPkg::hostBusT                  hostBus,
    output logic                             hostAck,
    output logic [hsdPkg::gpioWordWidth-1:0] hostReadData,
    output hsdPkg::regStrobesT               strobes,
    input  hsdPkg::statusWordsT              status
);

    typedef enum logic [1:0] {
        stateIdle,
        stateAccept,
        stateHold,
        stateRelease
    } busStateT;

    busStateT                         busState;
    logic                             acceptNow;
    logic [hsdPkg::gpioWordWidth-1:0] readWord;
    logic                             softStrobe;
    logic                             interlockStrobe;
    logic [hsdPkg::gpioWordWidth-1:0] writeDataReg;

    //////////////////////////////////////////////////////////////////////
    // Readback multiplexer
    always_comb begin
        case (hostBus.index)
            hsdPkg::gpioIdxBuildDate:    readWord = hsdPkg::firmwareBuildDate;
            hsdPkg::gpioIdxMicroseconds: readWord = status.microseconds;
            hsdPkg::gpioIdxInterlockCsr: readWord = status.interlockCsr;
            hsdPkg::gpioIdxUserGpioCsr:  readWord = status.userGpioCsr;
            // Soft trigger is write only and unused indices read zero
            default:                     readWord = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Four-phase slave
    assign acceptNow = (busState == stateIdle) && hostReq;

    always_ff @(posedge sysClk) begin
        if (reset) begin
            busState     <= stateIdle;
            hostAck      <= 1'b0;
            hostReadData <= '0;
        end else begin
            case (busState)
                stateIdle: begin
                    if (hostReq) begin
                        hostReadData <= readWord;
                        busState     <= stateAccept;
                    end
                end
                stateAccept: begin
                    hostAck  <= 1'b1;
                    busState <= stateHold;
                end
                stateHold: begin
                    // Wait for the host to drop its request
                    if (!hostReq) begin
                        busState <= stateRelease;
                    end
                end
                default: begin
                    hostAck  <= 1'b0;
                    busState <= stateIdle;
                end
            endcase
        end
    end

    // One-cycle write strobes at acceptance
    always_ff @(posedge sysClk) begin
        if (reset) begin
            softStrobe      <= 1'b0;
            interlockStrobe <= 1'b0;
        end else begin
            softStrobe <= acceptNow && hostBus.write &&
                          (hostBus.index == hsdPkg::gpioIdxSoftTrigger);
            interlockStrobe <= acceptNow && hostBus.write &&
                               (hostBus.index == hsdPkg::gpioIdxInterlockCsr);
        end
    end

    always_ff @(posedge sysClk) begin
        if (acceptNow) begin
            writeDataReg <= hostBus.data;
        end
    end

    assign strobes = '{softTrigger:    softStrobe,
                       interlockWrite: interlockStrobe,
                       writeData:      writeDataReg};

endmodule

// File: source/timekeeper.sv
`timescale 1ns/1ps

module timekeeper (
    input  logic                             sysClk,
    input  logic                             reset,
    output logic [hsdPkg::gpioWordWidth-1:0] microseconds
);

    logic [$clog2(hsdPkg::clksPerMicrosecond)-1:0] prescaler;
    logic                                          microsecondTick;

    //////////////////////////////////////////////////////////////////////
    // Prescaler wraps once per microsecond
    assign microsecondTick =
        (prescaler == $bits(prescaler)'(hsdPkg::clksPerMicrosecond - 1));

    always_ff @(posedge sysClk) begin
        if (reset) begin
            prescaler <= '0;
        end else if (microsecondTick) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Free-running microseconds since reset
    always_ff @(posedge sysClk) begin
        if (reset) begin
            microseconds <= '0;
        end else if (microsecondTick) begin
            microseconds <= microseconds + 1'b1;
        end
    end

endmodule

// File: source/triggerUnit.sv
`timescale 1ns/1ps

module triggerUnit (
    input  logic                               sysClk,
    input  logic                               reset,
    input  hsdPkg::regStrobesT                 strobes,
    input  logic [hsdPkg::evrTriggerWidth-1:0] evrTrigger,
    output logic [hsdPkg::acqTriggerWidth-1:0] acqTriggerStrobes
);

    logic [3:0]                         stretchCount;
    logic                               softTrigger;
    logic [hsdPkg::acqTriggerWidth-1:0] triggerIn;
    logic [hsdPkg::acqTriggerWidth-1:0] triggerMeta;
    logic [hsdPkg::acqTriggerWidth-1:0] triggerSync;
    logic [hsdPkg::acqTriggerWidth-1:0] triggerPrev;

    //////////////////////////////////////////////////////////////////////
    // Software trigger stretcher

    // Reload on every strobe, so a second write restarts the pulse
    always_ff @(posedge sysClk) begin
        if (reset) begin
            stretchCount <= '0;
        end else if (strobes.softTrigger) begin
            stretchCount <= 4'(hsdPkg::softTriggerStretch);
        end else if (stretchCount != '0) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    assign softTrigger = (stretchCount != '0);

    //////////////////////////////////////////////////////////////////////
    // Trigger merge, synchronizer and edge detect

    // Event triggers 0 and 1 are heartbeat and PPS, not acquisition triggers
    assign triggerIn = {evrTrigger[hsdPkg::evrTriggerWidth-1:2], softTrigger};

    always_ff @(posedge sysClk) begin
        if (reset) begin
            triggerMeta <= '0;
            triggerSync <= '0;
        end else begin
            triggerMeta <= triggerIn;
            triggerSync <= triggerMeta;
        end
    end

    // Strobe comes out on the third edge after the input is sampled
    always_ff @(posedge sysClk) begin
        if (reset) begin
            triggerPrev       <= '0;
            acqTriggerStrobes <= '0;
        end else begin
            triggerPrev       <= triggerSync;
            acqTriggerStrobes <= triggerSync & ~triggerPrev;
        end
    end

endmodule

// File: source/frontPanel.sv
`timescale 1ns/1ps

module frontPanel (
    input  logic                               sysClk,
    input  logic                               reset,
    input  hsdPkg::regStrobesT                 strobes,
    input  logic [hsdPkg::evrTriggerWidth-1:0] evrTrigger,
    input  logic                               swResetRecovery,
    input  logic                               swDisplay,
    input  logic                               swInterlockReset,
    input  logic [hsdPkg::dipWidth-1:0]        dipSwitch,
    output logic [hsdPkg::ledCount-1:0]        leds,
    output logic [hsdPkg::gpioWordWidth-1:0]   interlockCsr,
    output logic [hsdPkg::gpioWordWidth-1:0]   userGpioCsr
);

    logic [1:0] switchMeta;
    logic [1:0] switchSync;
    logic       resetRecoverySwitch;
    logic       displaySwitch;
    logic       relayControl;
    logic       relayOpen;
    logic       relayClosed;
    logic       evrHeartbeat;
    logic       evrPulsePerSecond;

    //////////////////////////////////////////////////////////////////////
    // Mode switches
    always_ff @(posedge sysClk) begin
        switchMeta <= {swResetRecovery, swDisplay};
        switchSync <= switchMeta;
    end

    assign resetRecoverySwitch = switchSync[1];
    assign displaySwitch       = switchSync[0];

    //////////////////////////////////////////////////////////////////////
    // Interlock relay
    always_ff @(posedge sysClk) begin
        if (reset) begin
            relayControl <= 1'b0;
        end else if (strobes.interlockWrite) begin
            relayControl <= strobes.writeData[0];
        end
    end

    // Without relay sense contacts the relay reads as closed
    assign relayOpen   = 1'b0;
    assign relayClosed = 1'b1;

    assign interlockCsr = {28'b0, relayClosed, relayOpen, 1'b0, swInterlockReset};

    //////////////////////////////////////////////////////////////////////
    // LEDs
    assign evrHeartbeat      = evrTrigger[0];
    assign evrPulsePerSecond = evrTrigger[1];

    assign leds = {swInterlockReset,
                   relayOpen,
                   relayClosed,
                   relayControl,
                   2'b00,
                   evrPulsePerSecond,
                   evrHeartbeat};

    // User status word with the DIP switches in the low byte
    assign userGpioCsr = {resetRecoverySwitch,
                          displaySwitch,
                          6'b0,
                          evrTrigger,
                          8'b0,
                          dipSwitch};

endmodule

// File: source/hsdTop.sv
`timescale 1ns/1ps

module hsdTop (
    input  logic                               sysClk,
    input  logic                               reset,
    input  logic                               hostReq,
    input  hsdPkg::hostBusT                    hostBus,
    output logic                               hostAck,
    output logic [hsdPkg::gpioWordWidth-1:0]   hostReadData,
    input  logic [hsdPkg::evrTriggerWidth-1:0] evrTrigger,
    input  logic                               swResetRecovery,
    input  logic                               swDisplay,
    input  logic                               swInterlockReset,
    input  logic [hsdPkg::dipWidth-1:0]        dipSwitch,
    output logic [hsdPkg::ledCount-1:0]        leds,
    output logic [hsdPkg::acqTriggerWidth-1:0] acqTriggerStrobes
);

    hsdPkg::regStrobesT  strobes;
    hsdPkg::statusWordsT status;

    //////////////////////////////////////////////////////////////////////
    // Host register file
    gpioRegisterBank gpioRegisterBank (
        .sysClk       (sysClk),
        .reset        (reset),
        .hostReq      (hostReq),
        .hostBus      (hostBus),
        .hostAck      (hostAck),
        .hostReadData (hostReadData),
        .strobes      (strobes),
        .status       (status)
    );

    //////////////////////////////////////////////////////////////////////
    // Timekeeping
    timekeeper timekeeper (
        .sysClk       (sysClk),
        .reset        (reset),
        .microseconds (status.microseconds)
    );

    //////////////////////////////////////////////////////////////////////
    // Acquisition triggers
    triggerUnit triggerUnit (
        .sysClk            (sysClk),
        .reset             (reset),
        .strobes           (strobes),
        .evrTrigger        (evrTrigger),
        .acqTriggerStrobes (acqTriggerStrobes)
    );

    //////////////////////////////////////////////////////////////////////
    // Switches, interlock and LEDs
    frontPanel frontPanel (
        .sysClk           (sysClk),
        .reset            (reset),
        .strobes          (strobes),
        .evrTrigger       (evrTrigger),
        .swResetRecovery  (swResetRecovery),
        .swDisplay        (swDisplay),
        .swInterlockReset (swInterlockReset),
        .dipSwitch        (dipSwitch),
        .leds             (leds),
        .interlockCsr     (status.interlockCsr),
        .userGpioCsr      (status.userGpioCsr)
    );

endmodule

// File: tb/hsdTopTb_assertions.sv
`timescale 1ns/1ps

module hsdTopAssertions (
    input logic                               sysClk,
    input logic                               reset,
    input logic                               hostReq,
    input logic                               hostAck,
    input hsdPkg::regStrobesT                 strobes,
    input logic [hsdPkg::acqTriggerWidth-1:0] acqTriggerStrobes
);

    int assertionFailures = 0;

    //////////////////////////////////////////////////////////////////////
    // Host bus handshake
    ackLowInReset: assert property (@(posedge sysClk) reset |=> !hostAck)
        else begin
            $error("hostAck is high after a reset cycle");
            assertionFailures++;
        end

    // Ack only ever answers a pending request
    ackNeedsReq: assert property (@(posedge sysClk) disable iff (reset)
        $rose(hostAck) |-> $past(hostReq))
        else begin
            $error("hostAck rose without hostReq");
            assertionFailures++;
        end

    //////////////////////////////////////////////////////////////////////
    // Strobe widths
    softStrobeOneCycle: assert property (@(posedge sysClk) disable iff (reset)
        strobes.softTrigger |=> !strobes.softTrigger)
        else begin
            $error("softTrigger strobe longer than one cycle");
            assertionFailures++;
        end

    interlockStrobeOneCycle: assert property (@(posedge sysClk) disable iff (reset)
        strobes.interlockWrite |=> !strobes.interlockWrite)
        else begin
            $error("interlockWrite strobe longer than one cycle");
            assertionFailures++;
        end

    softAcqStrobeOneCycle: assert property (@(posedge sysClk) disable iff (reset)
        acqTriggerStrobes[0] |=> !acqTriggerStrobes[0])
        else begin
            $error("acqTriggerStrobes bit 0 high two cycles running");
            assertionFailures++;
        end

endmodule

bind hsdTop hsdTopAssertions protocolChecks (
    .sysClk            (sysClk),
    .reset             (reset),
    .hostReq           (hostReq),
    .hostAck           (hostAck),
    .strobes           (strobes),
    .acqTriggerStrobes (acqTriggerStrobes)
);

// File: tb/hsdTopTb.sv
`timescale 1ns/1ps

module hsdTopTb;

    localparam time clkPeriod   = 100ns;
    localparam int  resetCycles = 8;
    localparam int  busTimeout  = 20;
    localparam int  tableLength = 13;

    typedef enum logic [2:0] {
        opRead, opWrite, opMicroseconds, opSoftTrigger, opEvrTrigger, opInterlock, opUserGpio
    } opKindT;

    typedef struct packed {
        opKindT      kind;
        logic [2:0]  index;
        logic [31:0] data;
        logic [31:0] expected;
    } stimRowT;

    // Kind, index, data (cycles for microseconds), expected word or pulse count
    stimRowT stimTable [tableLength] = '{
        '{opRead,         3'd0, 32'h0,         32'h2024_0611},
        '{opRead,         3'd5, 32'h0,         32'h0},
        '{opRead,         3'd7, 32'h0,         32'h0},
        '{opWrite,        3'd0, 32'hffff_ffff, 32'h0},
        '{opRead,         3'd0, 32'h0,         32'h2024_0611},
        '{opMicroseconds, 3'd1, 32'd100,       32'd10},
        '{opSoftTrigger,  3'd2, 32'h1,         32'h1},
        '{opEvrTrigger,   3'd0, 32'h0,         32'h1},
        '{opEvrTrigger,   3'd0, 32'h0,         32'h1},
        '{opInterlock,    3'd3, 32'h1,         32'h1},
        '{opInterlock,    3'd3, 32'h0,         32'h0},
        '{opUserGpio,     3'd4, 32'h0,         32'h0},
        '{opUserGpio,     3'd4, 32'h0,         32'h0}
    };

    logic            sysClk;
    logic            reset;
    logic            hostReq;
    hsdPkg::hostBusT hostBus;
    logic            hostAck;
    logic [31:0]     hostReadData;
    logic [7:0]      evrTrigger;
    logic            swResetRecovery;
    logic            swDisplay;
    logic            swInterlockReset;
    logic [7:0]      dipSwitch;
    logic [7:0]      leds;
    logic [6:0]      acqTriggerStrobes;

    int  errorCount;
    int  checkCount;
    int  pulseCount [7];
    time pulseTime [7];

    hsdTop u_dut (
        .sysClk            (sysClk),
        .reset             (reset),
        .hostReq           (hostReq),
        .hostBus           (hostBus),
        .hostAck           (hostAck),
        .hostReadData      (hostReadData),
        .evrTrigger        (evrTrigger),
        .swResetRecovery   (swResetRecovery),
        .swDisplay         (swDisplay),
        .swInterlockReset  (swInterlockReset),
        .dipSwitch         (dipSwitch),
        .leds              (leds),
        .acqTriggerStrobes (acqTriggerStrobes)
    );

    initial begin
        sysClk = 1'b0;
        forever #(clkPeriod / 2) sysClk = ~sysClk;
    end

    initial begin
        #(clkPeriod * (resetCycles + tableLength * 40));
        $display("Watchdog expired before the stimulus table finished");
        $display("STATUS: FAIL");
        $finish;
    end

    // Strobes are one cycle wide, so each pulse is seen at one falling edge
    always @(negedge sysClk) begin
        for (int i = 0; i < 7; i++) begin
            if (!reset && acqTriggerStrobes[i]) begin
                pulseCount[i] = pulseCount[i] + 1;
                pulseTime[i]  = $time;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
        errorCount++;
    endtask

    task automatic noteFailure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errorCount++;
    endtask

    // Four-phase transfer that starts and ends at a falling edge
    task automatic busTransfer(input logic write, input logic [2:0] index,
                               input logic [31:0] data, output logic [31:0] readData);
        int waitCycles;
        readData   = '0;
        hostBus    = '{write: write, index: index, data: data};
        hostReq    = 1'b1;
        waitCycles = 0;
        do begin
            @(negedge sysClk);
            waitCycles++;
        end while (!hostAck && waitCycles < busTimeout);
        if (!hostAck) begin
            noteFailure("host bus timed out waiting for hostAck to rise");
            hostReq = 1'b0;
            return;
        end
        readData = hostReadData;
        // Ack must hold as long as the request does
        repeat (2) begin
            @(negedge sysClk);
            checkCount++;
            if (hostAck !== 1'b1) begin
                reportMismatch("hostAck", 32'(hostAck), 32'h1);
            end
        end
        hostReq    = 1'b0;
        waitCycles = 0;
        do begin
            @(negedge sysClk);
            waitCycles++;
        end while (hostAck && waitCycles < busTimeout);
        if (hostAck) begin
            noteFailure("host bus timed out waiting for hostAck to fall");
        end
    endtask

    // Quiet acquisition trigger inputs and clear the pulse record
    task automatic settleTriggers();
        evrTrigger[7:2] = '0;
        repeat (6) @(negedge sysClk);
        for (int i = 0; i < 7; i++) begin
            pulseCount[i] = 0;
            pulseTime[i]  = 0;
        end
    endtask

    task automatic checkPulses(input int pulseBit, input int wantCount);
        int expectedCount;
        for (int i = 0; i < 7; i++) begin
            expectedCount = (i == pulseBit) ? wantCount : 0;
            checkCount++;
            if (pulseCount[i] != expectedCount) begin
                reportMismatch($sformatf("acqTriggerStrobes[%0d] pulses", i),
                               pulseCount[i], expectedCount);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] readData;
        logic [31:0] firstRead;
        logic [31:0] expectedWord;
        logic [7:0]  expectedLeds;
        time         startTime;
        int          bitIndex;
        int          elapsed;
        void'($urandom(32'h4452_7b61));
        reset            = 1'b1;
        hostReq          = 1'b0;
        hostBus          = '0;
        evrTrigger       = '0;
        swResetRecovery  = 1'b0;
        swDisplay        = 1'b0;
        swInterlockReset = 1'b0;
        dipSwitch        = '0;
        errorCount       = 0;
        checkCount       = 0;
        settleTriggers();
        repeat (resetCycles - 6) @(negedge sysClk);
        reset = 1'b0;
        @(negedge sysClk);

        foreach (stimTable[row]) begin
            case (stimTable[row].kind)
                opRead: begin
                    busTransfer(1'b0, stimTable[row].index, '0, readData);
                    checkCount++;
                    if (readData !== stimTable[row].expected) begin
                        reportMismatch("hostReadData", readData, stimTable[row].expected);
                    end
                end
                opWrite: begin
                    busTransfer(1'b1, stimTable[row].index, stimTable[row].data, readData);
                end
                opMicroseconds: begin
                    startTime = $time;
                    busTransfer(1'b0, stimTable[row].index, '0, firstRead);
                    while ($time < startTime + stimTable[row].data * clkPeriod) begin
                        @(negedge sysClk);
                    end
                    busTransfer(1'b0, stimTable[row].index, '0, readData);
                    elapsed = readData - firstRead;
                    checkCount++;
                    if (elapsed + 1 < int'(stimTable[row].expected) ||
                        elapsed > int'(stimTable[row].expected) + 1) begin
                        reportMismatch("microseconds delta", readData - firstRead,
                                       stimTable[row].expected);
                    end
                end
                opSoftTrigger: begin
                    settleTriggers();
                    startTime = $time;
                    busTransfer(1'b1, stimTable[row].index, stimTable[row].data, readData);
                    // Watch past the 15-cycle limit so a late strobe still shows
                    while ($time < startTime + 20 * clkPeriod) begin
                        @(negedge sysClk);
                    end
                    checkPulses(0, stimTable[row].expected);
                    checkCount++;
                    if (pulseCount[0] == 1 && pulseTime[0] - startTime > 15 * clkPeriod) begin
                        noteFailure("soft trigger strobe came later than 15 cycles");
                    end
                end
                opEvrTrigger: begin
                    settleTriggers();
                    bitIndex = 2 + ($urandom % 6);
                    evrTrigger[bitIndex] = 1'b1;
                    startTime = $time;
                    // Held high for the whole window, so a second pulse would show
                    repeat (10) @(negedge sysClk);
                    checkPulses(bitIndex - 1, stimTable[row].expected);
                    checkCount++;
                    if (pulseTime[bitIndex - 1] != startTime + 3 * clkPeriod) begin
                        noteFailure($sformatf("evrTrigger bit %0d strobe at %0t, wanted %0t",
                                    bitIndex, pulseTime[bitIndex - 1],
                                    startTime + 3 * clkPeriod));
                    end
                end
                opInterlock: begin
                    swInterlockReset = 1'($urandom);
                    evrTrigger[1:0]  = 2'($urandom);
                    busTransfer(1'b1, stimTable[row].index, stimTable[row].data, readData);
                    expectedLeds = {swInterlockReset, 1'b0, 1'b1, stimTable[row].expected[0],
                                    2'b00, evrTrigger[1:0]};
                    checkCount++;
                    if (leds !== expectedLeds) begin
                        reportMismatch("leds", leds, expectedLeds);
                    end
                    busTransfer(1'b0, stimTable[row].index, '0, readData);
                    expectedWord = {28'h0, 1'b1, 1'b0, 1'b0, swInterlockReset};
                    checkCount++;
                    if (readData !== expectedWord) begin
                        reportMismatch("interlockCsr", readData, expectedWord);
                    end
                end
                opUserGpio: begin
                    dipSwitch       = 8'($urandom);
                    evrTrigger      = 8'($urandom);
                    swResetRecovery = 1'($urandom);
                    swDisplay       = 1'($urandom);
                    repeat (3) @(negedge sysClk);
                    busTransfer(1'b0, stimTable[row].index, '0, readData);
                    expectedWord = {swResetRecovery, swDisplay, 6'h0, evrTrigger, 8'h0, dipSwitch};
                    checkCount++;
                    if (readData !== expectedWord) begin
                        reportMismatch("userGpioCsr", readData, expectedWord);
                    end
                end
                default: begin
                    noteFailure("unknown operation in the stimulus table");
                end
            endcase
        end

        errorCount = errorCount + u_dut.protocolChecks.assertionFailures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, u_dut.protocolChecks.assertionFailures);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
source/hsdPkg.sv
source/gpioRegisterBank.sv
source/timekeeper.sv
source/triggerUnit.sv
source/frontPanel.sv
source/hsdTop.sv
tb/hsdTopTb_assertions.sv
tb/hsdTopTb.sv
